// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps
// Testbench for the two-way blocking cache
// Random word traffic checked against a memory model and a cache model
module cache_tb;

  localparam int nsets     = 8;
  localparam int set_bits  = $clog2(nsets);
  localparam int num_reqs  = 2000;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 cachereq_val;
  logic                 cachereq_rdy;
  cache_pkg::msg_type_t cachereq_type;
  cache_pkg::addr_t     cachereq_addr;
  cache_pkg::word_t     cachereq_data;
  logic                 cacheresp_val;
  logic                 cacheresp_rdy;
  cache_pkg::msg_type_t cacheresp_type;
  cache_pkg::word_t     cacheresp_data;
  logic                 memreq_val;
  logic                 memreq_rdy;
  cache_pkg::msg_type_t memreq_type;
  cache_pkg::addr_t     memreq_addr;
  cache_pkg::line_t     memreq_data;
  logic                 memresp_val;
  logic                 memresp_rdy;
  cache_pkg::line_t     memresp_data;

  integer seed = 32'h5eba;

  // Backing memory and the last value written to every word
  cache_pkg::word_t mem_img [cache_pkg::addr_t];
  cache_pkg::word_t arch_img [cache_pkg::addr_t];

  // Cache model per set and way
  logic                  m_valid [nsets][2];
  logic                  m_dirty [nsets][2];
  cache_pkg::line_addr_t m_tag [nsets][2];
  logic                  m_lru [nsets];

  // Memory requests expected for the request in flight
  cache_pkg::msg_type_t exp_mtype [$];
  cache_pkg::addr_t     exp_maddr [$];
  cache_pkg::line_t     exp_mdata [$];

  blocking_cache #(.nsets(nsets)) dut (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_type    (memreq_type),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_data   (memresp_data)
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------
  // Error handling and compare tasks
  // ----------------------------------------------------------

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_now(input string why);
    $display("Error: %s", why);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_type(input string name, input cache_pkg::msg_type_t got,
                            input cache_pkg::msg_type_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input cache_pkg::addr_t got,
                            input cache_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_line(input string name, input cache_pkg::line_t got,
                            input cache_pkg::line_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------
  // Memory and cache models
  // ----------------------------------------------------------

  // Power-up memory contents mixed from the whole address
  function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic cache_pkg::word_t read_word(input bit from_arch,
                                                 input cache_pkg::addr_t a);
    if (from_arch && arch_img.exists(a)) begin
      return arch_img[a];
    end
    if (!from_arch && mem_img.exists(a)) begin
      return mem_img[a];
    end
    return init_word(a);
  endfunction

  // Word 0 sits in the low bits of the line
  function automatic cache_pkg::line_t read_line(input bit from_arch,
                                                 input cache_pkg::line_addr_t la);
    cache_pkg::line_t l;
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = read_word(from_arch, {la, i[1:0], 2'b00});
    end
    return l;
  endfunction

  // Applies one request to the cache model and queues the memory traffic it causes
  task automatic predict(input cache_pkg::msg_type_t t, input cache_pkg::addr_t a,
                         input cache_pkg::word_t d, output cache_pkg::word_t exp_data);
    int                    idx;
    int                    w;
    cache_pkg::line_addr_t la;
    idx = a[4 +: set_bits];
    la  = a[31:4];
    if (m_valid[idx][0] && m_tag[idx][0] == la) begin
      w = 0;
    end else if (m_valid[idx][1] && m_tag[idx][1] == la) begin
      w = 1;
    end else begin
      w = m_lru[idx];
      // Dirty victim goes back to memory before the refill
      if (m_valid[idx][w] && m_dirty[idx][w]) begin
        exp_mtype.push_back(cache_pkg::MSG_WRITE);
        exp_maddr.push_back({m_tag[idx][w], 4'b0000});
        exp_mdata.push_back(read_line(1'b1, m_tag[idx][w]));
      end
      exp_mtype.push_back(cache_pkg::MSG_READ);
      exp_maddr.push_back({la, 4'b0000});
      exp_mdata.push_back('0);
      m_valid[idx][w] = 1'b1;
      m_dirty[idx][w] = 1'b0;
      m_tag[idx][w]   = la;
    end
    if (t == cache_pkg::MSG_WRITE) begin
      arch_img[a]     = d;
      m_dirty[idx][w] = 1'b1;
      exp_data        = '0;
    end else begin
      exp_data = read_word(1'b1, a);
    end
    m_lru[idx] = (w == 0);
  endtask

  // ----------------------------------------------------------
  // One request from issue to accepted response
  // ----------------------------------------------------------

  task automatic run_request(input cache_pkg::msg_type_t t, input cache_pkg::addr_t a,
                             input cache_pkg::word_t d);
    cache_pkg::word_t exp_data;
    cache_pkg::line_t mem_line;
    int               timeout;
    int               mem_delay;
    logic             mem_busy;
    logic             mreq_hold;
    logic             resp_hold;
    logic             resp_done;
    logic             s_req_rdy;
    logic             s_resp_val;
    logic             s_resp_rdy;
    logic             s_mreq_val;
    logic             s_mreq_rdy;
    logic             s_mresp_val;
    logic             s_mresp_rdy;

    predict(t, a, d, exp_data);
    cachereq_val  <= 1'b1;
    cachereq_type <= t;
    cachereq_addr <= a;
    cachereq_data <= d;

    timeout = 0;
    do begin
      @(posedge clk);
      s_req_rdy = cachereq_rdy;
      timeout++;
      if (timeout > 20) begin
        fail_now("cache did not accept the request within 20 cycles");
      end
    end while (!s_req_rdy);

    // Scramble the request inputs so only registered copies are used
    cachereq_val  <= 1'b0;
    cachereq_addr <= $random(seed);
    cachereq_data <= $random(seed);

    mem_busy  = 1'b0;
    mem_delay = 0;
    mem_line  = '0;
    mreq_hold = 1'b0;
    resp_hold = 1'b0;
    resp_done = 1'b0;
    timeout   = 0;
    while (!resp_done) begin
      @(posedge clk);
      timeout++;
      if (timeout > 200) begin
        fail_now("no cache response within 200 cycles");
      end
      s_req_rdy   = cachereq_rdy;
      s_resp_val  = cacheresp_val;
      s_resp_rdy  = cacheresp_rdy;
      s_mreq_val  = memreq_val;
      s_mreq_rdy  = memreq_rdy;
      s_mresp_val = memresp_val;
      s_mresp_rdy = memresp_rdy;

      // No new request is taken while one is in flight
      check_bit("cachereq_rdy", s_req_rdy, 1'b0);

      // Memory request is checked every cycle it is held
      if (s_mreq_val) begin
        if (exp_mtype.size() == 0) begin
          fail_now("memory request issued where none was expected");
        end
        check_type("memreq_type", memreq_type, exp_mtype[0]);
        check_addr("memreq_addr", memreq_addr, exp_maddr[0]);
        if (exp_mtype[0] == cache_pkg::MSG_WRITE) begin
          check_line("memreq_data", memreq_data, exp_mdata[0]);
        end
        mreq_hold = !s_mreq_rdy;
        if (s_mreq_rdy) begin
          if (memreq_type == cache_pkg::MSG_WRITE) begin
            for (int i = 0; i < 4; i++) begin
              mem_img[{memreq_addr[31:4], i[1:0], 2'b00}] = memreq_data[32*i +: 32];
            end
            mem_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
          end else begin
            mem_line = read_line(1'b0, memreq_addr[31:4]);
          end
          void'(exp_mtype.pop_front());
          void'(exp_maddr.pop_front());
          void'(exp_mdata.pop_front());
          mem_busy  = 1'b1;
          mem_delay = $random(seed) & 3;
        end
      end else if (mreq_hold) begin
        fail_now("memory request withdrawn before it was taken");
      end

      // Memory response after a random delay
      if (s_mresp_val && s_mresp_rdy) begin
        memresp_val <= 1'b0;
      end
      if (mem_busy) begin
        if (mem_delay == 0) begin
          memresp_val  <= 1'b1;
          memresp_data <= mem_line;
          mem_busy = 1'b0;
        end else begin
          mem_delay--;
        end
      end

      // Held cache response fields must match every cycle
      if (s_resp_val) begin
        check_type("cacheresp_type", cacheresp_type, t);
        check_word("cacheresp_data", cacheresp_data, exp_data);
        resp_hold = !s_resp_rdy;
        resp_done = s_resp_rdy;
      end else if (resp_hold) begin
        fail_now("cache response withdrawn before it was taken");
      end

      memreq_rdy    <= ($random(seed) & 3) != 0;
      cacheresp_rdy <= ($random(seed) & 3) != 0;
    end

    if (exp_mtype.size() != 0) begin
      fail_now("an expected memory request was never issued");
    end
    if (mem_busy) begin
      fail_now("response finished while a memory reply was still pending");
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    cache_pkg::msg_type_t t;
    cache_pkg::addr_t     a;
    cache_pkg::word_t     d;
    int                   tsel;
    int                   isel;
    int                   wsel;

    reset         <= 1'b1;
    cachereq_val  <= 1'b0;
    cachereq_type <= cache_pkg::MSG_READ;
    cachereq_addr <= '0;
    cachereq_data <= '0;
    cacheresp_rdy <= 1'b0;
    memreq_rdy    <= 1'b0;
    memresp_val   <= 1'b0;
    memresp_data  <= '0;
    for (int s = 0; s < nsets; s++) begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
      m_dirty[s][0] = 1'b0;
      m_dirty[s][1] = 1'b0;
      m_lru[s]      = 1'b0;
    end

    repeat (8) @(posedge clk);
    check_bit("cachereq_rdy", cachereq_rdy, 1'b1);
    check_bit("cacheresp_val", cacheresp_val, 1'b0);
    check_bit("memreq_val", memreq_val, 1'b0);
    check_bit("memresp_rdy", memresp_rdy, 1'b0);
    reset <= 1'b0;

    // Four lines per set and four words per line keep conflicts frequent
    for (int n = 0; n < num_reqs; n++) begin
      tsel = $random(seed) & 3;
      isel = $random(seed) & (nsets - 1);
      wsel = $random(seed) & 3;
      a = 32'h0004_0000 + tsel * 32'h1000 + isel * 16 + wsel * 4;
      d = $random(seed);
      t = ($random(seed) & 1) ? cache_pkg::MSG_WRITE : cache_pkg::MSG_READ;
      run_request(t, a, d);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== design/blocking_cache.sv ====
`timescale 1ns/1ps
// Two-way set-associative blocking L1 cache, write-back and write-allocate
module blocking_cache #(
  parameter int nsets = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  input  cache_pkg::msg_type_t cachereq_type,
  input  cache_pkg::addr_t     cachereq_addr,
  input  cache_pkg::word_t     cachereq_data,
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,
  output cache_pkg::msg_type_t cacheresp_type,
  output cache_pkg::word_t     cacheresp_data,
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  output cache_pkg::msg_type_t memreq_type,
  output cache_pkg::addr_t     memreq_addr,
  output cache_pkg::line_t     memreq_data,
  input  logic                 memresp_val,
  output logic                 memresp_rdy,
  input  cache_pkg::line_t     memresp_data
);

  // Control to datapath
  logic req_en;
  logic memresp_en;
  logic is_refill;
  logic tag_wen_0;
  logic tag_wen_1;
  logic tag_ren;
  logic data_wen;
  logic data_ren;
  logic way_sel;
  logic read_data_en;
  logic victim_en;

  // Status back to control
  cache_pkg::msg_type_t     req_type;
  logic [$clog2(nsets)-1:0] req_idx;
  logic                     tag_match_0;
  logic                     tag_match_1;

  // Line state
  logic valid_wen;
  logic dirty_wen;
  logic dirty_in;
  logic lru_wen;
  logic valid_0;
  logic valid_1;
  logic dirty_0;
  logic dirty_1;
  logic lru_way;

  cache_ctrl ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_type      (req_type),
    .tag_match_0   (tag_match_0),
    .tag_match_1   (tag_match_1),
    .valid_0       (valid_0),
    .valid_1       (valid_1),
    .dirty_0       (dirty_0),
    .dirty_1       (dirty_1),
    .lru_way       (lru_way),
    .req_en        (req_en),
    .memresp_en    (memresp_en),
    .is_refill     (is_refill),
    .tag_wen_0     (tag_wen_0),
    .tag_wen_1     (tag_wen_1),
    .tag_ren       (tag_ren),
    .data_wen      (data_wen),
    .data_ren      (data_ren),
    .read_data_en  (read_data_en),
    .victim_en     (victim_en),
    .memreq_type   (memreq_type),
    .way_sel       (way_sel),
    .valid_wen     (valid_wen),
    .dirty_wen     (dirty_wen),
    .dirty_in      (dirty_in),
    .lru_wen       (lru_wen)
  );

  cache_line_state #(.nsets(nsets)) line_state (
    .clk       (clk),
    .reset     (reset),
    .idx       (req_idx),
    .way_sel   (way_sel),
    .valid_wen (valid_wen),
    .dirty_wen (dirty_wen),
    .dirty_in  (dirty_in),
    .lru_wen   (lru_wen),
    .valid_0   (valid_0),
    .valid_1   (valid_1),
    .dirty_0   (dirty_0),
    .dirty_1   (dirty_1),
    .lru_way   (lru_way)
  );

  cache_dpath #(.nsets(nsets)) dpath (
    .clk            (clk),
    .reset          (reset),
    .req_en         (req_en),
    .memresp_en     (memresp_en),
    .is_refill      (is_refill),
    .tag_wen_0      (tag_wen_0),
    .tag_wen_1      (tag_wen_1),
    .tag_ren        (tag_ren),
    .data_wen       (data_wen),
    .data_ren       (data_ren),
    .way_sel        (way_sel),
    .read_data_en   (read_data_en),
    .victim_en      (victim_en),
    .memreq_type    (memreq_type),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .memresp_data   (memresp_data),
    .req_type       (req_type),
    .req_idx        (req_idx),
    .tag_match_0    (tag_match_0),
    .tag_match_1    (tag_match_1),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data)
  );

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps
// Blocking cache controller
// Runs tag check, access, refill and eviction, and records the way in use
module cache_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  input  logic                 memresp_val,
  output logic                 memresp_rdy,
  input  cache_pkg::msg_type_t req_type,
  input  logic                 tag_match_0,
  input  logic                 tag_match_1,
  input  logic                 valid_0,
  input  logic                 valid_1,
  input  logic                 dirty_0,
  input  logic                 dirty_1,
  input  logic                 lru_way,
  output logic                 req_en,
  output logic                 memresp_en,
  output logic                 is_refill,
  output logic                 tag_wen_0,
  output logic                 tag_wen_1,
  output logic                 tag_ren,
  output logic                 data_wen,
  output logic                 data_ren,
  output logic                 read_data_en,
  output logic                 victim_en,
  output cache_pkg::msg_type_t memreq_type,
  output logic                 way_sel,
  output logic                 valid_wen,
  output logic                 dirty_wen,
  output logic                 dirty_in,
  output logic                 lru_wen
);

  localparam cache_pkg::msg_type_t RD = cache_pkg::MSG_READ;
  localparam cache_pkg::msg_type_t WR = cache_pkg::MSG_WRITE;

  cache_pkg::ctrl_state_t state;
  cache_pkg::ctrl_state_t state_next;

  logic hit_0;
  logic hit_1;
  logic hit;
  logic victim_dirty;
  logic way_record_en;
  logic way_record_in;
  logic tag_wen;
  logic memresp_load;

  assign hit_0 = valid_0 && tag_match_0;
  assign hit_1 = valid_1 && tag_match_1;
  assign hit   = hit_0 || hit_1;

  // Victim is the LRU way, written back only if valid and dirty
  assign victim_dirty = lru_way ? (valid_1 && dirty_1) : (valid_0 && dirty_0);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::IDLE:
        if (cachereq_val) state_next = cache_pkg::TAG_CHECK;
      cache_pkg::TAG_CHECK:
        if (hit && req_type == WR) state_next = cache_pkg::WRITE_ACCESS;
        else if (hit)              state_next = cache_pkg::READ_ACCESS;
        else if (victim_dirty)     state_next = cache_pkg::EVICT_PREPARE;
        else                       state_next = cache_pkg::REFILL_REQUEST;
      cache_pkg::REFILL_REQUEST:
        if (memreq_rdy) state_next = cache_pkg::REFILL_WAIT;
      cache_pkg::REFILL_WAIT:
        if (memresp_val) state_next = cache_pkg::REFILL_UPDATE;
      cache_pkg::REFILL_UPDATE:
        if (req_type == WR) state_next = cache_pkg::WRITE_ACCESS;
        else                state_next = cache_pkg::READ_ACCESS;
      cache_pkg::EVICT_PREPARE:
        state_next = cache_pkg::EVICT_REQUEST;
      cache_pkg::EVICT_REQUEST:
        if (memreq_rdy) state_next = cache_pkg::EVICT_WAIT;
      cache_pkg::EVICT_WAIT:
        if (memresp_val) state_next = cache_pkg::REFILL_REQUEST;
      cache_pkg::READ_ACCESS,
      cache_pkg::WRITE_ACCESS:
        state_next = cache_pkg::WAIT;
      cache_pkg::WAIT:
        if (cacheresp_rdy) state_next = cache_pkg::IDLE;
      default:
        state_next = cache_pkg::IDLE;
    endcase
  end

  // Way record, hit way or LRU way on a miss
  assign way_record_in = hit_0 ? 1'b0 : (hit_1 ? 1'b1 : lru_way);

  always_ff @(posedge clk) begin
    if (reset) begin
      way_sel <= 1'b0;
    end else if (way_record_en) begin
      way_sel <= way_record_in;
    end
  end

  // ----------------------------------------------------------
  // Per-state control table
  // ----------------------------------------------------------

  task automatic cs(
    input logic                 c_req_rdy,
    input logic                 c_resp_val,
    input logic                 c_mreq_val,
    input logic                 c_mresp_rdy,
    input logic                 c_req_en,
    input logic                 c_mresp_load,
    input logic                 c_is_refill,
    input logic                 c_tag_wen,
    input logic                 c_tag_ren,
    input logic                 c_data_wen,
    input logic                 c_data_ren,
    input logic                 c_read_data_en,
    input logic                 c_victim_en,
    input cache_pkg::msg_type_t c_memreq_type,
    input logic                 c_valid_wen,
    input logic                 c_dirty_wen,
    input logic                 c_dirty_in,
    input logic                 c_lru_wen,
    input logic                 c_way_record_en
  );
    cachereq_rdy  = c_req_rdy;
    cacheresp_val = c_resp_val;
    memreq_val    = c_mreq_val;
    memresp_rdy   = c_mresp_rdy;
    req_en        = c_req_en;
    memresp_load  = c_mresp_load;
    is_refill     = c_is_refill;
    tag_wen       = c_tag_wen;
    tag_ren       = c_tag_ren;
    data_wen      = c_data_wen;
    data_ren      = c_data_ren;
    read_data_en  = c_read_data_en;
    victim_en     = c_victim_en;
    memreq_type   = c_memreq_type;
    valid_wen     = c_valid_wen;
    dirty_wen     = c_dirty_wen;
    dirty_in      = c_dirty_in;
    lru_wen       = c_lru_wen;
    way_record_en = c_way_record_en;
  endtask

  //   rdy val mrq mrs ren mld rfl twe tre dwe dre rde vic type vwe dwe din lru way
  always_comb begin
    case (state)
      cache_pkg::IDLE:           cs(1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
      cache_pkg::TAG_CHECK:      cs(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, RD, 0, 0, 0, 0, 1);
      cache_pkg::READ_ACCESS:    cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, RD, 0, 0, 0, 1, 0);
      cache_pkg::WRITE_ACCESS:   cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, RD, 0, 1, 1, 1, 0);
      cache_pkg::REFILL_REQUEST: cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
      cache_pkg::REFILL_WAIT:    cs(0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
      cache_pkg::REFILL_UPDATE:  cs(0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 0, 0, 0, RD, 1, 1, 0, 0, 0);
      cache_pkg::EVICT_PREPARE:  cs(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 1, RD, 0, 0, 0, 0, 0);
      cache_pkg::EVICT_REQUEST:  cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, WR, 0, 0, 0, 0, 0);
      cache_pkg::EVICT_WAIT:     cs(0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
      cache_pkg::WAIT:           cs(0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
      default:                   cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, RD, 0, 0, 0, 0, 0);
    endcase
  end

  // Line register only loads on the beat that carries data
  assign memresp_en = memresp_load && memresp_val;
  assign tag_wen_0  = tag_wen && !way_sel;
  assign tag_wen_1  = tag_wen && way_sel;

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------

  // A memory request is never withdrawn before it is taken
  a_memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val);

  a_inputs_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({cachereq_val, cacheresp_rdy, memreq_rdy, memresp_val}));

endmodule

// ==== design/cache_data_array.sv ====
`timescale 1ns/1ps
// Line storage of one cache way
// Byte-enabled write, registered read returning new data on a write
module cache_data_array #(
  parameter int nsets = 8
) (
  input  logic                     clk,
  input  logic [$clog2(nsets)-1:0] idx,
  input  logic                     wen,
  input  cache_pkg::wben_t         wben,
  input  cache_pkg::line_t         wdata,
  output cache_pkg::line_t         rdata
);

  cache_pkg::line_t mem [nsets];
  cache_pkg::line_t merged;

  // Old line with the enabled bytes replaced
  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < $bits(cache_pkg::wben_t); b++) begin
      if (wben[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[idx] <= merged;
    end
    // Write-first so an access right after a refill sees the new line
    rdata <= wen ? merged : mem[idx];
  end

endmodule

// ==== design/cache_dpath.sv ====
`timescale 1ns/1ps
// Cache datapath with request registers, tag and data arrays,
// read word select and memory request forming
module cache_dpath #(
  parameter int nsets = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_en,
  input  logic                     memresp_en,
  input  logic                     is_refill,
  input  logic                     tag_wen_0,
  input  logic                     tag_wen_1,
  input  logic                     tag_ren,
  input  logic                     data_wen,
  input  logic                     data_ren,
  input  logic                     way_sel,
  input  logic                     read_data_en,
  input  logic                     victim_en,
  input  cache_pkg::msg_type_t     memreq_type,
  input  cache_pkg::msg_type_t     cachereq_type,
  input  cache_pkg::addr_t         cachereq_addr,
  input  cache_pkg::word_t         cachereq_data,
  input  cache_pkg::line_t         memresp_data,
  output cache_pkg::msg_type_t     req_type,
  output logic [$clog2(nsets)-1:0] req_idx,
  output logic                     tag_match_0,
  output logic                     tag_match_1,
  output cache_pkg::msg_type_t     cacheresp_type,
  output cache_pkg::word_t         cacheresp_data,
  output cache_pkg::addr_t         memreq_addr,
  output cache_pkg::line_t         memreq_data
);

  cache_pkg::addr_t      req_addr;
  cache_pkg::word_t      req_data;
  cache_pkg::line_t      resp_line;
  cache_pkg::line_addr_t req_line_addr;
  cache_pkg::word_off_t  req_off;
  cache_pkg::line_addr_t tags [2][nsets];
  cache_pkg::line_addr_t tag_rd;
  cache_pkg::line_addr_t victim_tag;
  cache_pkg::line_t      victim_line;
  cache_pkg::line_t      wdata;
  cache_pkg::wben_t      wben;
  cache_pkg::line_t      rdata_0;
  cache_pkg::line_t      rdata_1;
  cache_pkg::line_t      sel_line;
  cache_pkg::word_t      read_data;

  // Request and memory response registers
  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= cache_pkg::MSG_READ;
    end else if (req_en) begin
      req_type <= cachereq_type;
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
    if (memresp_en) begin
      resp_line <= memresp_data;
    end
  end

  assign req_line_addr = req_addr[31:4];
  assign req_off       = req_addr[3:2];
  assign req_idx       = req_addr[4 +: $clog2(nsets)];

  // ----------------------------------------------------------
  // Tag arrays
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tag_wen_0) begin
      tags[0][req_idx] <= req_line_addr;
    end
    if (tag_wen_1) begin
      tags[1][req_idx] <= req_line_addr;
    end
  end

  assign tag_match_0 = tag_ren && (tags[0][req_idx] == req_line_addr);
  assign tag_match_1 = tag_ren && (tags[1][req_idx] == req_line_addr);
  assign tag_rd      = tag_ren ? tags[way_sel][req_idx] : '0;

  // ----------------------------------------------------------
  // Data arrays
  // ----------------------------------------------------------

  // Refill writes the whole line, a store only its word
  assign wdata = is_refill ? resp_line : {4{req_data}};
  assign wben  = is_refill ? '1 : (cache_pkg::wben_t'(16'hf) << {req_off, 2'b00});

  cache_data_array #(.nsets(nsets)) data_array_0 (
    .clk   (clk),
    .idx   (req_idx),
    .wen   (data_wen && !way_sel),
    .wben  (wben),
    .wdata (wdata),
    .rdata (rdata_0)
  );

  cache_data_array #(.nsets(nsets)) data_array_1 (
    .clk   (clk),
    .idx   (req_idx),
    .wen   (data_wen && way_sel),
    .wben  (wben),
    .wdata (wdata),
    .rdata (rdata_1)
  );

  assign sel_line = data_ren ? (way_sel ? rdata_1 : rdata_0) : '0;

  // Read word and victim registers
  always_ff @(posedge clk) begin
    if (read_data_en) begin
      read_data <= sel_line[{req_off, 5'd0} +: 32];
    end
    if (victim_en) begin
      victim_line <= sel_line;
      victim_tag  <= tag_rd;
    end
  end

  assign cacheresp_type = req_type;
  assign cacheresp_data = (req_type == cache_pkg::MSG_WRITE) ? '0 : read_data;

  // Eviction goes to the victim's line, refill to the request's line
  assign memreq_addr = (memreq_type == cache_pkg::MSG_WRITE) ? {victim_tag, 4'b0000}
                                                             : {req_line_addr, 4'b0000};
  assign memreq_data = victim_line;

endmodule

// ==== design/cache_line_state.sv ====
`timescale 1ns/1ps
// Per-set valid, dirty and LRU bits of both ways
module cache_line_state #(
  parameter int nsets = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [$clog2(nsets)-1:0] idx,
  input  logic                     way_sel,
  input  logic                     valid_wen,
  input  logic                     dirty_wen,
  input  logic                     dirty_in,
  input  logic                     lru_wen,
  output logic                     valid_0,
  output logic                     valid_1,
  output logic                     dirty_0,
  output logic                     dirty_1,
  output logic                     lru_way
);

  // One bit per set, first index is the way
  logic [nsets-1:0] valid_q [2];
  logic [nsets-1:0] dirty_q [2];
  logic [nsets-1:0] lru_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      dirty_q[0] <= '0;
      dirty_q[1] <= '0;
      lru_q      <= '0;
    end else begin
      // A line only becomes valid on refill
      if (valid_wen) begin
        valid_q[way_sel][idx] <= 1'b1;
      end
      if (dirty_wen) begin
        dirty_q[way_sel][idx] <= dirty_in;
      end
      // Other way becomes LRU after an access
      if (lru_wen) begin
        lru_q[idx] <= !way_sel;
      end
    end
  end

  assign valid_0 = valid_q[0][idx];
  assign valid_1 = valid_q[1][idx];
  assign dirty_0 = dirty_q[0][idx];
  assign dirty_1 = dirty_q[1][idx];
  assign lru_way = lru_q[idx];

  // Dirty data without a valid line would be lost on eviction
  a_dirty_valid: assert property (@(posedge clk) disable iff (reset)
    ((dirty_q[0] & ~valid_q[0]) | (dirty_q[1] & ~valid_q[1])) == '0);

endmodule

// ==== design/cache_pkg.sv ====
// Shared types for the two-way blocking L1 cache
// Widths, memory message codes and controller states
package cache_pkg;

  // Byte address and data word
  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;

  // Four words per line
  typedef logic [127:0] line_t;

  // Byte address without the offset bits, stored whole in the tag arrays
  typedef logic [27:0]  line_addr_t;

  typedef logic [1:0]   word_off_t;

  // One enable per byte of a line
  typedef logic [15:0]  wben_t;

  // Request and response type field
  typedef logic [2:0]   msg_type_t;

  localparam msg_type_t MSG_READ  = 3'd0;
  localparam msg_type_t MSG_WRITE = 3'd1;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    REFILL_REQUEST,
    REFILL_WAIT,
    REFILL_UPDATE,
    EVICT_PREPARE,
    EVICT_REQUEST,
    EVICT_WAIT,
    WAIT
  } ctrl_state_t;

endpackage

// ==== files.f ====
design/cache_pkg.sv
design/cache_data_array.sv
design/cache_line_state.sv
design/cache_dpath.sv
design/cache_ctrl.sv
design/blocking_cache.sv
bench/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the blocking cache testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cache_tb -f files.f -o cache_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/cache_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
